// ==== hw/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address into the memory space.
`define PHYSICAL_ADDR_WIDTH 16

// one cache line per bus beat.
`define LINE_WIDTH 64

// line address drops the byte offset within a line.
`define LINE_ADDR_WIDTH (`PHYSICAL_ADDR_WIDTH - $clog2(`LINE_WIDTH / 8))

`define MEM_LATENCY 4 // queue stages per bus direction.

`define MAX_BEATS 16

// a beat count must be able to hold MAX_BEATS itself.
`define BEAT_WIDTH ($clog2(`MAX_BEATS + 1))

// lines held by the core, upper line-address bits alias.
`define MEM_LINES 256

`endif

// ==== hw/mem_pkg.sv ====
`default_nettype none

`include "mem_macros.svh"

package mem_pkg;

    // one line request as it travels through the bus.
    typedef struct packed {
        logic                        read;
        logic                        write;
        logic [`LINE_ADDR_WIDTH-1:0] line_addr;
        logic [`LINE_WIDTH-1:0]      line_data;
    } line_request_t;

    // read data or write acknowledgement.
    typedef struct packed {
        logic                   valid;
        logic [`LINE_WIDTH-1:0] line_data;
    } line_response_t;

    typedef enum logic [1:0] {
        burst_idle,
        burst_issue,   // one strobe per cycle.
        burst_drain,   // waiting for the remaining responses.
        burst_finish
    } burst_state_t;

endpackage

`default_nettype wire

// ==== hw/mem_line_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

interface mem_line_if;

    logic                        read;      // single-cycle strobe.
    logic                        write;     // single-cycle strobe.
    logic [`LINE_ADDR_WIDTH-1:0] line_addr;
    logic [`LINE_WIDTH-1:0]      line_data;

    // one pulse per strobe, in issue order.
    logic                        rsp_valid;
    logic [`LINE_WIDTH-1:0]      rsp_data;

    modport requester (
        output read,
        output write,
        output line_addr,
        output line_data,
        input  rsp_valid,
        input  rsp_data
    );

    modport responder (
        input  read,
        input  write,
        input  line_addr,
        input  line_data,
        output rsp_valid,
        output rsp_data
    );

endinterface

`default_nettype wire

// ==== hw/mem_core_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_core_bus
    import mem_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    mem_line_if.responder host_side,
    mem_line_if.requester core_side
);

    line_request_t  req_queue [`MEM_LATENCY];
    line_response_t rsp_queue [`MEM_LATENCY];
    line_request_t  req_in;
    line_response_t rsp_in;

    assign req_in = '{
        read:      host_side.read,
        write:     host_side.write,
        line_addr: host_side.line_addr,
        line_data: host_side.line_data
    };

    assign rsp_in = '{
        valid:     core_side.rsp_valid,
        line_data: core_side.rsp_data
    };

    // both directions shift every cycle, there is no stall.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_LATENCY; i++) begin
                req_queue[i].read  <= 1'b0;
                req_queue[i].write <= 1'b0;
                rsp_queue[i].valid <= 1'b0;
            end
            core_side.read      <= 1'b0;
            core_side.write     <= 1'b0;
            host_side.rsp_valid <= 1'b0;
        end else begin
            req_queue[0] <= req_in;
            rsp_queue[0] <= rsp_in;
            for (int i = 1; i < `MEM_LATENCY; i++) begin
                req_queue[i] <= req_queue[i-1];
                rsp_queue[i] <= rsp_queue[i-1];
            end

            // output stage adds the final cycle of each direction.
            core_side.read      <= req_queue[`MEM_LATENCY-1].read;
            core_side.write     <= req_queue[`MEM_LATENCY-1].write;
            core_side.line_addr <= req_queue[`MEM_LATENCY-1].line_addr;
            core_side.line_data <= req_queue[`MEM_LATENCY-1].line_data;

            host_side.rsp_valid <= rsp_queue[`MEM_LATENCY-1].valid;
            host_side.rsp_data  <= rsp_queue[`MEM_LATENCY-1].line_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_core
    import mem_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    mem_line_if.responder bus
);

    localparam int index_width = $clog2(`MEM_LINES);

    logic [`LINE_WIDTH-1:0] lines [`MEM_LINES];
    line_request_t          req;
    logic [index_width-1:0] index;  // upper line-address bits are ignored.
    logic                   rsp_valid_q;
    logic [`LINE_WIDTH-1:0] rsp_data_q;

    assign req = '{
        read:      bus.read,
        write:     bus.write,
        line_addr: bus.line_addr,
        line_data: bus.line_data
    };

    assign index = req.line_addr[index_width-1:0];

    always_ff @(posedge clock) begin
        if (req.write) begin
            lines[index] <= req.line_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req.read || req.write;
        end
    end

    // a write is acknowledged with the line it stored.
    always_ff @(posedge clock) begin
        rsp_data_q <= req.write ? req.line_data : lines[index];
    end

    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_data  = rsp_data_q;

endmodule

`default_nettype wire

// ==== hw/mem_beat_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_beat_counter (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   issue,
    input  logic                   retire,
    input  logic [`BEAT_WIDTH-1:0] beat_count,
    output logic                   last_issue,
    output logic                   last_retire
);

    logic [`BEAT_WIDTH-1:0] burst_len;
    logic [`BEAT_WIDTH-1:0] total_q;
    logic [`BEAT_WIDTH-1:0] issued_q;
    logic [`BEAT_WIDTH-1:0] retired_q;

    // zero beats runs as a single beat.
    assign burst_len = (beat_count == '0) ? 1'b1 : beat_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            total_q   <= '0;
            issued_q  <= '0;
            retired_q <= '0;
        end else if (load) begin
            total_q   <= burst_len;
            issued_q  <= '0;
            retired_q <= '0;
        end else begin
            if (issue) begin
                issued_q <= issued_q + 1'b1;
            end
            if (retire) begin
                retired_q <= retired_q + 1'b1;
            end
        end
    end

    assign last_issue  = issue && (issued_q == total_q - 1'b1);
    assign last_retire = retire && (retired_q == total_q - 1'b1);

endmodule

`default_nettype wire

// ==== hw/mem_burst_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_burst_fsm
    import mem_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        write,
    input  logic [`LINE_ADDR_WIDTH-1:0] start_addr,
    input  logic [`LINE_WIDTH-1:0]      wr_data,
    input  logic                        last_issue,
    input  logic                        last_retire,
    output logic                        wr_take,
    output logic                        rd_valid,
    output logic                        busy,
    output logic                        done,
    output logic                        load,
    output logic                        issue,
    output logic                        retire,
    output logic [`LINE_WIDTH-1:0]      rd_data,
    mem_line_if.requester               bus
);

    burst_state_t                state_q;
    burst_state_t                state_d;
    logic                        write_q;  // direction of the running burst.
    logic [`LINE_ADDR_WIDTH-1:0] addr_q;
    line_request_t               req;
    logic                        accept;

    assign accept = start && !busy;  // finish also takes a new command.

    always_comb begin
        state_d = state_q;
        case (state_q)
            burst_idle: begin
                if (accept) begin
                    state_d = burst_issue;
                end
            end
            burst_issue: begin
                if (last_issue) begin
                    state_d = burst_drain;
                end
            end
            burst_drain: begin
                if (last_retire) begin
                    state_d = burst_finish;
                end
            end
            default: begin
                state_d = accept ? burst_issue : burst_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= burst_idle;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                write_q <= write;
            end
        end
    end

    // line address wraps in its own width.
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= start_addr;
        end else if (issue) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign busy    = (state_q == burst_issue) || (state_q == burst_drain);
    assign done    = (state_q == burst_finish);
    assign load    = accept;
    assign issue   = (state_q == burst_issue);
    assign retire  = bus.rsp_valid;

    assign wr_take  = issue && write_q;  // wr_data goes out in this cycle.
    assign rd_valid = bus.rsp_valid && !write_q;
    assign rd_data  = bus.rsp_data;

    assign req = '{
        read:      issue && !write_q,
        write:     issue && write_q,
        line_addr: addr_q,
        line_data: wr_data
    };

    assign bus.read      = req.read;
    assign bus.write     = req.write;
    assign bus.line_addr = req.line_addr;
    assign bus.line_data = req.line_data;

endmodule

`default_nettype wire

// ==== hw/mem_burst_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_burst_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        write,
    input  logic [`LINE_ADDR_WIDTH-1:0] start_addr,
    input  logic [`BEAT_WIDTH-1:0]      beat_count,
    input  logic [`LINE_WIDTH-1:0]      wr_data,
    output logic                        wr_take,
    output logic                        rd_valid,
    output logic [`LINE_WIDTH-1:0]      rd_data,
    output logic                        busy,
    output logic                        done
);

    logic load;
    logic issue;
    logic retire;
    logic last_issue;
    logic last_retire;

    mem_line_if host_line ();  // engine to bus.
    mem_line_if core_line ();  // bus to core.

    mem_burst_fsm u_fsm (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .write       (write),
        .start_addr  (start_addr),
        .wr_data     (wr_data),
        .last_issue  (last_issue),
        .last_retire (last_retire),
        .wr_take     (wr_take),
        .rd_valid    (rd_valid),
        .busy        (busy),
        .done        (done),
        .load        (load),
        .issue       (issue),
        .retire      (retire),
        .rd_data     (rd_data),
        .bus         (host_line.requester)
    );

    mem_beat_counter u_counter (
        .clock       (clock),
        .reset       (reset),
        .load        (load),
        .issue       (issue),
        .retire      (retire),
        .beat_count  (beat_count),
        .last_issue  (last_issue),
        .last_retire (last_retire)
    );

    mem_core_bus u_bus (
        .clock     (clock),
        .reset     (reset),
        .host_side (host_line.responder),
        .core_side (core_line.requester)
    );

    mem_core u_core (
        .clock (clock),
        .reset (reset),
        .bus   (core_line.responder)
    );

endmodule

`default_nettype wire

// ==== verif/mem_burst_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_burst_props (
    input logic clock,
    input logic reset,
    input logic start,
    input logic write,
    input logic busy,
    input logic done,
    input logic wr_take,
    input logic rd_valid
);

    logic dir_q;  // direction of the accepted burst.

    always_ff @(posedge clock) begin
        if (reset) begin
            dir_q <= 1'b0;
        end else if (start && !busy) begin
            dir_q <= write;
        end
    end

    busy_after_start: assert property (@(posedge clock) disable iff (reset)
        start && !busy |=> busy) else $error("busy did not rise after start");

    take_only_busy: assert property (@(posedge clock) disable iff (reset)
        wr_take |-> busy) else $error("wr_take while idle");

    done_single: assert property (@(posedge clock) disable iff (reset)
        done |=> !done) else $error("done longer than one cycle");

    idle_after_done: assert property (@(posedge clock) disable iff (reset)
        done && !start |=> !busy) else $error("busy after done");

    take_in_write: assert property (@(posedge clock) disable iff (reset)
        wr_take |-> dir_q) else $error("wr_take in a read burst");

    read_in_read: assert property (@(posedge clock) disable iff (reset)
        rd_valid |-> !dir_q) else $error("rd_valid in a write burst");

endmodule

bind mem_burst_top mem_burst_props u_props (
    .clock    (clock),
    .reset    (reset),
    .start    (start),
    .write    (write),
    .busy     (busy),
    .done     (done),
    .wr_take  (wr_take),
    .rd_valid (rd_valid)
);

`default_nettype wire

// ==== verif/mem_burst_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_macros.svh"

module mem_burst_tb;

    localparam int done_timeout = 64;  // cycles, well above the longest burst.
    localparam int read_latency = 2 * `MEM_LATENCY + 4;

    logic                        clock;
    logic                        reset;
    logic                        start;
    logic                        write;
    logic [`LINE_ADDR_WIDTH-1:0] start_addr;
    logic [`BEAT_WIDTH-1:0]      beat_count;
    logic [`LINE_WIDTH-1:0]      wr_data;
    logic                        wr_take;
    logic                        rd_valid;
    logic [`LINE_WIDTH-1:0]      rd_data;
    logic                        busy;
    logic                        done;

    logic [`LINE_WIDTH-1:0]      ref_mem [int];  // indexed by core line.
    logic [`LINE_WIDTH-1:0]      expected_q [$];
    logic [`LINE_ADDR_WIDTH-1:0] wr_addr;
    logic [`LINE_WIDTH-1:0]      next_line;
    integer                      seed;
    int                          wr_count;
    int                          rd_count;
    int                          done_count;
    int                          error_count;
    int                          check_count;
    int                          test_count;
    int                          errors_before;
    int                          latency;
    int                          run_len;

    mem_burst_top u_dut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .write      (write),
        .start_addr (start_addr),
        .beat_count (beat_count),
        .wr_data    (wr_data),
        .wr_take    (wr_take),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // the core keeps only the low line-address bits.
    function automatic logic [`LINE_WIDTH-1:0] expected_line(
        input logic [`LINE_ADDR_WIDTH-1:0] addr
    );
        int index;
        index = int'(addr) % `MEM_LINES;
        if (ref_mem.exists(index)) begin
            return ref_mem[index];
        end
        return 'x;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // supply a fresh random line whenever the engine asks for one.
    always @(negedge clock) begin
        if (!reset && wr_take) begin
            next_line = {$random(seed), $random(seed)};
            wr_data = next_line;
            ref_mem[int'(wr_addr) % `MEM_LINES] = next_line;
            wr_addr = wr_addr + 1'b1;
            wr_count++;
        end
    end

    always @(negedge clock) begin
        if (!reset && rd_valid) begin
            rd_count++;
            if (expected_q.size() == 0) begin
                error_count++;
                $display("read data arrived with no read outstanding");
            end else begin
                check("rd_data", rd_data, expected_q.pop_front());
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && done) begin
            done_count++;
        end
    end

    task automatic pulse_start(input logic dir, input logic [`LINE_ADDR_WIDTH-1:0] addr,
                               input logic [`BEAT_WIDTH-1:0] count);
        start = 1'b1;
        write = dir;
        start_addr = addr;
        beat_count = count;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic begin_burst(input logic dir, input logic [`LINE_ADDR_WIDTH-1:0] addr,
                               input logic [`BEAT_WIDTH-1:0] count);
        int                          len;
        logic [`LINE_ADDR_WIDTH-1:0] a;
        len = (count == 0) ? 1 : count;
        wr_addr = addr;
        wr_count = 0;
        rd_count = 0;
        done_count = 0;
        a = addr;
        if (!dir) begin
            for (int i = 0; i < len; i++) begin
                expected_q.push_back(expected_line(a));
                a = a + 1'b1;  // wraps like the engine's address.
            end
        end
        pulse_start(dir, addr, count);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < done_timeout) begin
            @(negedge clock);
            n++;
        end
        if (!done) begin
            error_count++;
            $display("timeout: burst did not finish within %0d cycles", done_timeout);
        end else begin
            check("busy", busy, 1'b0);  // busy falls with done.
        end
        @(negedge clock);
    endtask

    task automatic check_counts(input logic dir, input int len);
        check("wr_take count", wr_count, dir ? len : 0);
        check("rd_valid count", rd_count, dir ? 0 : len);
        check("done count", done_count, 1);
        check("pending reads", expected_q.size(), 0);
    endtask

    task automatic run_burst(input logic dir, input logic [`LINE_ADDR_WIDTH-1:0] addr,
                             input logic [`BEAT_WIDTH-1:0] count);
        begin_burst(dir, addr, count);
        wait_done();
        check_counts(dir, (count == 0) ? 1 : count);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        seed = 11;
        reset = 1'b1;
        start = 1'b0;
        write = 1'b0;
        start_addr = '0;
        beat_count = '0;
        wr_data = '0;
        wr_addr = '0;
        wr_count = 0;
        rd_count = 0;
        done_count = 0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        errors_before = 0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        run_burst(1'b1, 13'h0040, 5'd16);
        run_burst(1'b0, 13'h0040, 5'd16);
        end_test("full burst write and read back");

        run_burst(1'b1, 13'h0100, 5'd1);
        run_burst(1'b0, 13'h0100, 5'd1);
        run_burst(1'b1, 13'h0101, 5'd0);
        run_burst(1'b0, 13'h0101, 5'd0);
        end_test("single beat and zero beat count");

        run_burst(1'b1, 13'h1ffe, 5'd6);
        run_burst(1'b0, 13'h1ffe, 5'd6);
        run_burst(1'b0, 13'h00fe, 5'd4);  // aliases the wrapped lines.
        end_test("address wrap and aliasing");

        begin_burst(1'b0, 13'h0044, 5'd8);
        latency = 1;
        while (!rd_valid && latency < done_timeout) begin
            @(negedge clock);
            latency++;
        end
        check("read latency", latency, read_latency);
        run_len = 0;
        while (rd_valid && run_len < done_timeout) begin
            run_len++;
            @(negedge clock);
        end
        check("rd_valid run", run_len, 8);
        check("done", done, 1'b1);
        wait_done();
        check_counts(1'b0, 8);
        end_test("read timing");

        begin_burst(1'b0, 13'h0040, 5'd8);
        repeat (3) @(negedge clock);
        check("busy", busy, 1'b1);
        pulse_start(1'b1, 13'h0100, 5'd3);  // must be dropped while busy.
        wait_done();
        check_counts(1'b0, 8);
        run_burst(1'b0, 13'h0048, 5'd4);
        end_test("start while busy");

        run_burst(1'b1, 13'h0200, 5'd8);
        run_burst(1'b1, 13'h0202, 5'd4);
        run_burst(1'b1, 13'h0305, 5'd2);
        run_burst(1'b0, 13'h0200, 5'd8);
        end_test("overwrite");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/mem_pkg.sv
hw/mem_line_if.sv
hw/mem_core_bus.sv
hw/mem_core.sv
hw/mem_beat_counter.sv
hw/mem_burst_fsm.sv
hw/mem_burst_top.sv
verif/mem_burst_props.sv
verif/mem_burst_tb.sv

// ==== Bender.yml ====
package:
  name: mem_burst

sources:
  # rtl
  - include_dirs:
      - hw
    files:
      - hw/mem_pkg.sv
      - hw/mem_line_if.sv
      - hw/mem_core_bus.sv
      - hw/mem_core.sv
      - hw/mem_beat_counter.sv
      - hw/mem_burst_fsm.sv
      - hw/mem_burst_top.sv
  # verification
  - target: test
    include_dirs:
      - hw
    files:
      - verif/mem_burst_props.sv
      - verif/mem_burst_tb.sv
